//--- hdl/corr_pkg.sv
`default_nettype none

package corr_pkg;

   // ------------------------------
   // array sizes
   // ------------------------------
   localparam int NUM_ANT    = 4;  // one-bit (sign) antennas
   localparam int NUM_BASE   = 6;  // antenna pairs, NUM_ANT*(NUM_ANT-1)/2
   localparam int BASE_W     = 3;  // baseline address bits
   localparam int BCOUNT_W   = 12; // block size minus one
   localparam int ACC_W      = 16; // holds a full 4096-frame block
   localparam int PIPE_DEPTH = 2;  // sampled frame -> accumulate

   // ------------------------------
   // baseline -> antenna map
   // ------------------------------
   // baseline order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int BASE_ANT_A [0:NUM_BASE-1] = '{0, 0, 0, 1, 1, 2}; // first antenna
   localparam int BASE_ANT_B [0:NUM_BASE-1] = '{1, 2, 3, 2, 3, 3}; // second antenna

   // readout block flags
   typedef enum logic [1:0] {
      VIS_EMPTY,   // nothing finished, or already read
      VIS_READY,   // one finished block waiting
      VIS_OVERRUN  // a block was overwritten before it was read
   } vis_state_t;

endpackage

`default_nettype wire

//--- hdl/bank_switch.sv
`timescale 1ns/1ns
`default_nettype none

module bank_switch (
   input  wire                          clk_x,
   input  wire                          sw_d,     // async reset, active high
   input  wire                          frame_i,  // new set of samples
   input  wire [corr_pkg::BCOUNT_W-1:0] bcount_i, // block size minus one
   output logic                         swap_o,   // one-cycle, end of block
   output logic                         bank_o    // active bank index
);

   logic [corr_pkg::BCOUNT_W-1:0]   count_q;  // frames seen in this block
   logic [corr_pkg::PIPE_DEPTH-1:0] end_q;    // block-end delay line
   logic                            last_frm; // this frame closes the block
   logic                            bank_q;

   // ------------------------------
   // frame counter
   // ------------------------------
   assign last_frm = frame_i && (count_q == bcount_i);

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         count_q <= '0;
      end else if (frame_i) begin
         if (count_q == bcount_i)
            count_q <= '0; // wrap after the last frame
         else
            count_q <= count_q + 1'b1;
      end
   end

   // ------------------------------
   // swap delay and bank toggle
   // ------------------------------
   // the block end has to trail the agreement register and the
   // accumulator add, so the last frame lands in the old bank
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         end_q <= '0;
      end else begin
         end_q <= {end_q[corr_pkg::PIPE_DEPTH-2:0], last_frm}; // shift in
      end
   end

   assign swap_o = end_q[corr_pkg::PIPE_DEPTH-1]; // high the cycle after N+1

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d)
         bank_q <= 1'b0;
      else if (swap_o)
         bank_q <= ~bank_q; // flips at N+2
   end

   assign bank_o = bank_q;

   // swap pulses are single cycles, each block closes on its own frame
   a_swap_single : assert property (
      @(posedge clk_x) disable iff (sw_d)
      swap_o |=> !swap_o
   ) else $error("swap_o high on two consecutive cycles");

endmodule

`default_nettype wire

//--- hdl/baseline_corr.sv
`timescale 1ns/1ns
`default_nettype none

module baseline_corr (
   input  wire                       clk_x,
   input  wire                       sw_d,     // async reset, active high
   input  wire                       frame_i,  // samples valid this cycle
   input  wire                       ant_a_i,  // sign bit, first antenna
   input  wire                       ant_b_i,  // sign bit, second antenna
   input  wire                       swap_i,   // end-of-block pulse
   input  wire                       bank_i,   // bank taking new counts
   output logic [corr_pkg::ACC_W-1:0] vis_o    // frozen bank
);

   logic                      valid_q;  // a frame was sampled
   logic                      agree_q;  // both signs equal
   logic                      hit;      // count this frame
   logic [corr_pkg::ACC_W-1:0] inc;     // zero or one, full width
   logic [corr_pkg::ACC_W-1:0] acc_q [0:1]; // double-buffered counts
   logic [corr_pkg::ACC_W-1:0] acc_act; // bank currently accumulating

   // ------------------------------
   // agreement stage
   // ------------------------------
   // one-bit samples correlate by xnor
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         valid_q <= 1'b0;
         agree_q <= 1'b0;
      end else begin
         valid_q <= frame_i;
         agree_q <= ant_a_i ~^ ant_b_i;
      end
   end

   assign hit = valid_q && agree_q;
   assign inc = {{(corr_pkg::ACC_W-1){1'b0}}, hit};

   // ------------------------------
   // accumulator banks
   // ------------------------------
   // on the swap edge bank_i still names the old bank, so the
   // increment goes straight into the other one as its start value
   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d) begin
         acc_q[0] <= '0;
         acc_q[1] <= '0;
      end else if (swap_i) begin
         acc_q[~bank_i] <= inc;                  // fresh block, old one kept
      end else begin
         acc_q[bank_i] <= acc_q[bank_i] + inc;   // normal accumulate
      end
   end

   assign acc_act = acc_q[bank_i];
   assign vis_o   = acc_q[~bank_i]; // host side sees the idle bank

   // block sizes are limited so a full block never overflows
   a_no_wrap : assert property (
      @(posedge clk_x) disable iff (sw_d)
      (!swap_i && hit) |-> (acc_act != {corr_pkg::ACC_W{1'b1}})
   ) else $error("active accumulator about to wrap");

endmodule

`default_nettype wire

//--- hdl/vis_readout.sv
`timescale 1ns/1ns
`default_nettype none

module vis_readout (
   input  wire                                                clk_x,
   input  wire                                                sw_d,
   input  wire                                                swap_i, // block done
   input  wire [corr_pkg::NUM_BASE-1:0][corr_pkg::ACC_W-1:0] vis_i,  // frozen banks
   input  wire                                                rd_i,
   input  wire [corr_pkg::BASE_W-1:0]                         rd_addr_i,
   output logic [corr_pkg::ACC_W-1:0]                         rd_data_o,
   output logic                                               rd_valid_o,
   output logic                                               vis_ready_o,
   output logic                                               overrun_o
);

   corr_pkg::vis_state_t       state_q, state_d;
   logic                       last_rd;  // read of the final baseline
   logic [corr_pkg::ACC_W-1:0] rd_sel;   // addressed vis value
   logic [corr_pkg::ACC_W-1:0] rd_data_q;
   logic                       rd_valid_q;

   assign last_rd = rd_i && (int'(rd_addr_i) == corr_pkg::NUM_BASE - 1);

   // ------------------------------
   // block flag FSM
   // ------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         corr_pkg::VIS_EMPTY: begin
            if (swap_i) state_d = corr_pkg::VIS_READY;
         end
         corr_pkg::VIS_READY, corr_pkg::VIS_OVERRUN: begin
            if (swap_i && last_rd)
               state_d = corr_pkg::VIS_READY;   // read drains old, swap is new
            else if (swap_i)
               state_d = corr_pkg::VIS_OVERRUN; // unread block lost
            else if (last_rd)
               state_d = corr_pkg::VIS_EMPTY;   // host finished the block
         end
         default: state_d = corr_pkg::VIS_EMPTY;
      endcase
   end

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d)
         state_q <= corr_pkg::VIS_EMPTY;
      else
         state_q <= state_d;
   end

   assign vis_ready_o = (state_q != corr_pkg::VIS_EMPTY);
   assign overrun_o   = (state_q == corr_pkg::VIS_OVERRUN);

   // ------------------------------
   // addressed read
   // ------------------------------
   always_comb begin
      if (int'(rd_addr_i) < corr_pkg::NUM_BASE)
         rd_sel = vis_i[rd_addr_i];
      else
         rd_sel = '0; // unused addresses read zero
   end

   always_ff @(posedge clk_x) begin
      if (rd_i) rd_data_q <= rd_sel; // held until the next read
   end

   always_ff @(posedge clk_x or posedge sw_d) begin
      if (sw_d)
         rd_valid_q <= 1'b0;
      else
         rd_valid_q <= rd_i; // one cycle after the strobe
   end

   assign rd_data_o  = rd_data_q;
   assign rd_valid_o = rd_valid_q;

   // host only addresses real baselines
   a_addr_range : assert property (
      @(posedge clk_x) disable iff (sw_d)
      rd_i |-> (int'(rd_addr_i) < corr_pkg::NUM_BASE)
   ) else $error("read address beyond last baseline");

endmodule

`default_nettype wire

//--- hdl/correlator_top.sv
`timescale 1ns/1ns
`default_nettype none

module correlator_top (
   input  wire                          clk_x,
   input  wire                          sw_d,      // async reset, active high
   input  wire                          frame_i,   // sample strobe
   input  wire [corr_pkg::NUM_ANT-1:0]  ant_i,     // one sign bit per antenna
   input  wire [corr_pkg::BCOUNT_W-1:0] bcount_i,  // frames per block minus one
   input  wire                          rd_i,      // host read strobe
   input  wire [corr_pkg::BASE_W-1:0]   rd_addr_i, // baseline to read
   output logic [corr_pkg::ACC_W-1:0]   rd_data_o,
   output logic                         rd_valid_o,
   output logic                         vis_ready_o,
   output logic                         overrun_o
);

   logic                                              swap; // end-of-block pulse
   logic                                              bank; // active bank
   logic [corr_pkg::NUM_BASE-1:0][corr_pkg::ACC_W-1:0] vis; // frozen counts

   // ------------------------------
   // block control
   // ------------------------------
   bank_switch u_bank_switch (
      .clk_x    (clk_x),
      .sw_d     (sw_d),
      .frame_i  (frame_i),
      .bcount_i (bcount_i),
      .swap_o   (swap),
      .bank_o   (bank)
   );

   // ------------------------------
   // one correlator per baseline
   // ------------------------------
   for (genvar g = 0; g < corr_pkg::NUM_BASE; g++) begin : g_base
      baseline_corr u_corr (
         .clk_x   (clk_x),
         .sw_d    (sw_d),
         .frame_i (frame_i),
         .ant_a_i (ant_i[corr_pkg::BASE_ANT_A[g]]), // pair from the table
         .ant_b_i (ant_i[corr_pkg::BASE_ANT_B[g]]),
         .swap_i  (swap),
         .bank_i  (bank),
         .vis_o   (vis[g])
      );
   end

   // host side flags and reads
   vis_readout u_readout (
      .clk_x       (clk_x),
      .sw_d        (sw_d),
      .swap_i      (swap),
      .vis_i       (vis),
      .rd_i        (rd_i),
      .rd_addr_i   (rd_addr_i),
      .rd_data_o   (rd_data_o),
      .rd_valid_o  (rd_valid_o),
      .vis_ready_o (vis_ready_o),
      .overrun_o   (overrun_o)
   );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk_o // free-running testbench clock
);

   // ------------------------------
   // 100 ns period, 50/50 duty
   // ------------------------------
   localparam int HALF_NS = 50;

   initial begin
      clk_o = 1'b0;               // first rising edge at 50 ns
      forever #HALF_NS clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

//--- testbench/tb_correlator.sv
`timescale 1ns/1ns
`default_nettype none

module tb_correlator;

   typedef logic [corr_pkg::NUM_ANT-1:0]                  ant_t;
   typedef logic [corr_pkg::BCOUNT_W-1:0]                 bcnt_t;
   typedef logic [corr_pkg::BASE_W-1:0]                   addr_t;
   typedef logic [corr_pkg::ACC_W-1:0]                    acc_t;
   typedef logic [corr_pkg::NUM_BASE*corr_pkg::ACC_W-1:0] blk_t;  // all baselines, packed

   // ------------------------------
   // run limits
   // ------------------------------
   localparam int MAX_GAP     = 3;                        // idle cycles after a frame
   localparam int FRAME_CYC   = 2 + MAX_GAP;              // worst case per gapped frame
   localparam int READ_CYC    = 2 * corr_pkg::NUM_BASE;   // one full readout
   localparam int NUM_FRAMES  = 5 + 8 + 8 + 32 + 32 + 3;  // frames over all tests
   localparam int NUM_READOUT = 6;                        // full readouts over all tests
   localparam int READY_WAIT  = corr_pkg::PIPE_DEPTH + 4; // block end to vis_ready_o
   localparam int TIMEOUT_CYC = NUM_FRAMES * FRAME_CYC + NUM_READOUT * READ_CYC + 200;

   logic  clk_x;
   logic  sw_d;
   logic  frame;
   ant_t  ant;
   bcnt_t bcount;
   logic  rd;
   addr_t rd_addr;
   acc_t  rd_data;
   logic  rd_valid;
   logic  vis_ready;
   logic  overrun;

   int   seed   = 51;
   int   cycles = 0;                   // timeout counter
   int   blk_len;                      // frames per block, model side
   int   frm_cnt;                      // frames in the open block
   int   cur_cnt [corr_pkg::NUM_BASE]; // agreements in the open block
   blk_t blk_q [$];                    // finished blocks, oldest first

   tb_clock u_clock (.clk_o(clk_x));

   correlator_top dut0 (
      .clk_x       (clk_x),
      .sw_d        (sw_d),
      .frame_i     (frame),
      .ant_i       (ant),
      .bcount_i    (bcount),
      .rd_i        (rd),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data),
      .rd_valid_o  (rd_valid),
      .vis_ready_o (vis_ready),
      .overrun_o   (overrun)
   );

   // ------------------------------
   // error stop and compares
   // ------------------------------
   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_vis(input string name, input acc_t got, input acc_t exp);
      if (got !== exp)
         fail_stop($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_stop($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   // ------------------------------
   // reference model
   // ------------------------------
   task automatic model_clear();
      frm_cnt = 0;
      foreach (cur_cnt[b]) begin
         cur_cnt[b] = 0;
      end
      blk_q.delete();
   endtask

   // sign bits agree -> one count on that baseline
   task automatic model_frame(input ant_t a);
      blk_t blk;
      frm_cnt++;
      for (int b = 0; b < corr_pkg::NUM_BASE; b++) begin
         if (a[corr_pkg::BASE_ANT_A[b]] == a[corr_pkg::BASE_ANT_B[b]])
            cur_cnt[b]++;
      end
      if (frm_cnt == blk_len) begin
         for (int b = 0; b < corr_pkg::NUM_BASE; b++) begin
            blk[b*corr_pkg::ACC_W +: corr_pkg::ACC_W] = acc_t'(cur_cnt[b]);
            cur_cnt[b] = 0;
         end
         blk_q.push_back(blk); // block closed
         frm_cnt = 0;
      end
   endtask

   task automatic next_block(output blk_t blk);
      if (blk_q.size() == 0)
         fail_stop("vis_ready_o high but the model has no finished block");
      else
         blk = blk_q.pop_front();
   endtask

   function automatic ant_t rand_ant();
      return ant_t'($random(seed));
   endfunction

   function automatic int rand_gap();
      return int'({$random(seed)} % (MAX_GAP + 1)); // 0 .. MAX_GAP
   endfunction

   // ------------------------------
   // drivers
   // ------------------------------
   task automatic apply_reset();
      sw_d    <= 1'b1;
      frame   <= 1'b0;
      ant     <= '0;
      rd      <= 1'b0;
      rd_addr <= '0;
      repeat (3) @(posedge clk_x);
      sw_d <= 1'b0;
      model_clear();
   endtask

   task automatic set_bcount(input int n);
      @(posedge clk_x);
      bcount  <= bcnt_t'(n);
      blk_len = n + 1;       // bcount_i is frames minus one
   endtask

   task automatic send_frame(input ant_t a, input int gap);
      @(posedge clk_x);
      frame <= 1'b1;
      ant   <= a;
      model_frame(a);
      @(posedge clk_x);
      frame <= 1'b0;
      ant   <= rand_ant();   // junk while idle, must not count
      repeat (gap) @(posedge clk_x);
   endtask

   // one frame every cycle
   task automatic send_burst(input int n);
      ant_t a;
      repeat (n) begin
         @(posedge clk_x);
         a = rand_ant();
         frame <= 1'b1;
         ant   <= a;
         model_frame(a);
      end
      @(posedge clk_x);
      frame <= 1'b0;
   endtask

   task automatic read_base(input addr_t addr, output acc_t data);
      @(posedge clk_x);
      rd      <= 1'b1;
      rd_addr <= addr;
      @(negedge clk_x);
      check_flag("rd_valid_o", rd_valid, 1'b0); // strobe not sampled yet
      @(posedge clk_x);
      rd <= 1'b0;
      @(negedge clk_x);
      check_flag("rd_valid_o", rd_valid, 1'b1); // one cycle after the strobe
      data = rd_data;
   endtask

   // last address read drops both flags
   task automatic read_all(input blk_t exp);
      acc_t val;
      for (int b = 0; b < corr_pkg::NUM_BASE; b++) begin
         read_base(addr_t'(b), val);
         check_vis($sformatf("rd_data_o[%0d]", b), val,
                   exp[b*corr_pkg::ACC_W +: corr_pkg::ACC_W]);
      end
      check_flag("vis_ready_o", vis_ready, 1'b0);
      check_flag("overrun_o", overrun, 1'b0);
   endtask

   task automatic wait_flags(input logic want_ovr, input int max_cyc);
      int n;
      n = 0;
      @(negedge clk_x);
      while (!(vis_ready && (overrun || !want_ovr)) && n < max_cyc) begin
         n++;
         @(negedge clk_x);
      end
      if (!(vis_ready && (overrun || !want_ovr))) begin
         if (want_ovr)
            fail_stop("overrun_o did not rise after the second unread block ended");
         else
            fail_stop("vis_ready_o did not rise after the block ended");
      end
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic after_reset_flags();
      apply_reset();
      @(negedge clk_x);
      check_flag("vis_ready_o", vis_ready, 1'b0);
      check_flag("overrun_o", overrun, 1'b0);
      check_flag("rd_valid_o", rd_valid, 1'b0);
      set_bcount(7);
      repeat (5) send_frame(rand_ant(), rand_gap()); // short of 8 frames
      repeat (READY_WAIT) @(negedge clk_x);
      check_flag("vis_ready_o", vis_ready, 1'b0);
   endtask

   task automatic all_agree_block();
      blk_t exp;
      blk_t drop;
      apply_reset();
      repeat (8) send_frame('0, 2);
      wait_flags(1'b0, READY_WAIT);
      next_block(drop);
      for (int b = 0; b < corr_pkg::NUM_BASE; b++) begin
         exp[b*corr_pkg::ACC_W +: corr_pkg::ACC_W] = acc_t'(8); // every frame agrees
      end
      read_all(exp);
   endtask

   task automatic random_block();
      blk_t exp;
      repeat (8) send_frame(rand_ant(), rand_gap());
      wait_flags(1'b0, READY_WAIT);
      next_block(exp);
      read_all(exp);
   endtask

   // next block's first add lands on the swap edge
   task automatic back_to_back_blocks();
      blk_t exp;
      set_bcount(15);
      fork
         send_burst(2 * blk_len);
         begin
            wait_flags(1'b0, 2 * blk_len + READY_WAIT);
            next_block(exp);
            read_all(exp);  // done before the second block closes
            wait_flags(1'b0, 2 * blk_len + READY_WAIT);
            next_block(exp);
            read_all(exp);
         end
      join
   endtask

   task automatic overrun_block();
      blk_t exp;
      send_burst(2 * blk_len);
      wait_flags(1'b1, READY_WAIT);
      next_block(exp);       // lost in the DUT
      next_block(exp);
      read_all(exp);
   endtask

   task automatic shorter_block();
      blk_t exp;
      set_bcount(2);
      repeat (2) send_frame(rand_ant(), rand_gap());
      repeat (READY_WAIT) @(negedge clk_x);
      check_flag("vis_ready_o", vis_ready, 1'b0); // still one frame short
      send_frame(rand_ant(), rand_gap());
      wait_flags(1'b0, READY_WAIT);
      next_block(exp);
      read_all(exp);
   endtask

   initial begin
      bcount <= '0;
      after_reset_flags();
      all_agree_block();
      random_block();
      back_to_back_blocks();
      overrun_block();
      shorter_block();
      $display("Everything OK");
      $finish;
   end

   // hang guard
   always @(posedge clk_x) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYC)
         fail_stop($sformatf("Timeout after %0d cycles, the tests did not finish", cycles));
   end

endmodule

`default_nettype wire

//--- src.f
hdl/corr_pkg.sv
hdl/bank_switch.sv
hdl/baseline_corr.sv
hdl/vis_readout.sv
hdl/correlator_top.sv
testbench/tb_clock.sv
testbench/tb_correlator.sv

//--- run_sim.sh
#!/bin/sh
# build and run the correlator testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f src.f --top-module tb_correlator \
   -o sim_correlator > build.log 2>&1 \
   && ./obj_dir/sim_correlator > sim.log 2>&1 \
   || echo "build or simulation stopped with an error"
if grep -q "Everything OK" sim.log 2>/dev/null; then
   echo "PASS"
   exit 0
fi
echo "FAIL, see build.log and sim.log"
exit 1
